// File: hw/arena_params.svh
`ifndef ARENA_PARAMS_SVH
`define ARENA_PARAMS_SVH

// horizontal geometry in pixels
`define ARENA_H_ACTIVE 32
`define ARENA_H_FRONT 2
`define ARENA_H_SYNC 4
`define ARENA_H_BACK 2

// vertical geometry in lines
`define ARENA_V_ACTIVE 24
`define ARENA_V_FRONT 1
`define ARENA_V_SYNC 2
`define ARENA_V_BACK 1

`define ARENA_SPRITE_SIZE 4

// start positions, top left texel
`define ARENA_P1_START_X 4
`define ARENA_P1_START_Y 10
`define ARENA_P2_START_X 24
`define ARENA_P2_START_Y 10

`define ARENA_P1_COLOR 24'hFF0000
`define ARENA_P2_COLOR 24'h0000FF

`endif

// File: hw/arena_pkg.sv
package arena_pkg;

    // pixel or line coordinate, covers the blanking counts too
    typedef logic [5:0] coord_t;

    // background word address, y*32+x
    typedef logic [9:0] sram_addr_t;

    // rgb565 background word
    typedef logic [15:0] sram_word_t;

    typedef logic [23:0] rgb_t;

    typedef enum logic {
        IDLE,
        PLAY
    } game_state_t;

    // background write handshake
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_WRITE,
        WR_ACK
    } wr_state_t;

endpackage

// File: hw/raster_timing.sv
`include "arena_params.svh"

module raster_timing (
    input  logic              i_clk,
    input  logic              i_rst_n,
    output arena_pkg::coord_t o_fetch_x,
    output arena_pkg::coord_t o_fetch_y,
    output logic              o_fetch_active,
    output logic              o_frame_start,
    output logic              o_h_sync,
    output logic              o_v_sync
);
    localparam arena_pkg::coord_t H_LAST = `ARENA_H_ACTIVE + `ARENA_H_FRONT +
                                           `ARENA_H_SYNC + `ARENA_H_BACK - 1;
    localparam arena_pkg::coord_t V_LAST = `ARENA_V_ACTIVE + `ARENA_V_FRONT +
                                           `ARENA_V_SYNC + `ARENA_V_BACK - 1;
    localparam arena_pkg::coord_t H_ACTIVE = `ARENA_H_ACTIVE;
    localparam arena_pkg::coord_t V_ACTIVE = `ARENA_V_ACTIVE;
    localparam arena_pkg::coord_t H_SYNC_START = `ARENA_H_ACTIVE + `ARENA_H_FRONT;
    localparam arena_pkg::coord_t H_SYNC_END = H_SYNC_START + `ARENA_H_SYNC;
    localparam arena_pkg::coord_t V_SYNC_START = `ARENA_V_ACTIVE + `ARENA_V_FRONT;
    localparam arena_pkg::coord_t V_SYNC_END = V_SYNC_START + `ARENA_V_SYNC;

    arena_pkg::coord_t h_cnt;
    arena_pkg::coord_t v_cnt;
    logic              h_sync_raw;
    logic              v_sync_raw;
    logic              h_sync_d1;
    logic              v_sync_d1;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_LAST) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign o_fetch_x      = h_cnt;
    assign o_fetch_y      = v_cnt;
    assign o_fetch_active = (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);

    // first cycle of the vertical front porch
    assign o_frame_start = (v_cnt == V_ACTIVE) && (h_cnt == '0);

    assign h_sync_raw = !((h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END));
    assign v_sync_raw = !((v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END));

    // two stages, same as the decoder pipeline
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            h_sync_d1 <= 1'b1;
            v_sync_d1 <= 1'b1;
            o_h_sync  <= 1'b1;
            o_v_sync  <= 1'b1;
        end else begin
            h_sync_d1 <= h_sync_raw;
            v_sync_d1 <= v_sync_raw;
            o_h_sync  <= h_sync_d1;
            o_v_sync  <= v_sync_d1;
        end
    end

endmodule

// File: hw/game_control.sv
`include "arena_params.svh"

module game_control (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_start,
    input  logic              i_restart,
    input  logic              i_right,
    input  logic              i_left,
    input  logic              i_jump,
    input  logic              i_squat,
    input  logic              i_frame_start,
    output arena_pkg::coord_t o_p1_x,
    output arena_pkg::coord_t o_p1_y,
    output arena_pkg::coord_t o_p2_x,
    output arena_pkg::coord_t o_p2_y
);
    // sprite must stay fully on screen
    localparam arena_pkg::coord_t X_MAX = `ARENA_H_ACTIVE - `ARENA_SPRITE_SIZE;
    localparam arena_pkg::coord_t Y_MAX = `ARENA_V_ACTIVE - `ARENA_SPRITE_SIZE;
    localparam arena_pkg::coord_t P1_X0 = `ARENA_P1_START_X;
    localparam arena_pkg::coord_t P1_Y0 = `ARENA_P1_START_Y;
    localparam arena_pkg::coord_t P2_X0 = `ARENA_P2_START_X;
    localparam arena_pkg::coord_t P2_Y0 = `ARENA_P2_START_Y;

    arena_pkg::game_state_t state;
    arena_pkg::coord_t      p1_x;
    arena_pkg::coord_t      p1_y;
    arena_pkg::coord_t      p2_x;
    arena_pkg::coord_t      p2_y;

    // opposite buttons cancel out
    function automatic arena_pkg::coord_t step_clamped(
        input arena_pkg::coord_t pos,
        input logic              inc,
        input logic              dec,
        input arena_pkg::coord_t lim
    );
        arena_pkg::coord_t next;
        next = pos;
        if (inc && !dec && (pos < lim)) begin
            next = pos + 1'b1;
        end else if (dec && !inc && (pos != '0)) begin
            next = pos - 1'b1;
        end
        return next;
    endfunction

    function automatic arena_pkg::coord_t step_toward(
        input arena_pkg::coord_t pos,
        input arena_pkg::coord_t target
    );
        arena_pkg::coord_t next;
        next = pos;
        if (pos < target) begin
            next = pos + 1'b1;
        end else if (pos > target) begin
            next = pos - 1'b1;
        end
        return next;
    endfunction

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= arena_pkg::IDLE;
            p1_x  <= P1_X0;
            p1_y  <= P1_Y0;
            p2_x  <= P2_X0;
            p2_y  <= P2_Y0;
        end else if (i_restart) begin
            state <= arena_pkg::IDLE;
            p1_x  <= P1_X0;
            p1_y  <= P1_Y0;
            p2_x  <= P2_X0;
            p2_y  <= P2_Y0;
        end else begin
            case (state)
                arena_pkg::IDLE: begin
                    if (i_start) begin
                        state <= arena_pkg::PLAY;
                    end
                end
                arena_pkg::PLAY: begin
                    // player 2 chases the position held during the last frame
                    if (i_frame_start) begin
                        p1_x <= step_clamped(p1_x, i_right, i_left, X_MAX);
                        p1_y <= step_clamped(p1_y, i_squat, i_jump, Y_MAX);
                        p2_x <= step_toward(p2_x, p1_x);
                        p2_y <= step_toward(p2_y, p1_y);
                    end
                end
                default: state <= arena_pkg::IDLE;
            endcase
        end
    end

    assign o_p1_x = p1_x;
    assign o_p1_y = p1_y;
    assign o_p2_x = p2_x;
    assign o_p2_y = p2_y;

endmodule

// File: hw/sprite_table.sv
module sprite_table (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic [1:0] i_p1_row,
    input  logic [1:0] i_p1_col,
    input  logic [1:0] i_p2_row,
    input  logic [1:0] i_p2_col,
    output logic       o_p1_opaque,
    output logic       o_p2_opaque
);
    // row 0 in the top nibble, column 0 at its msb
    localparam logic [15:0] P1_MASK = 16'b0110_1111_1111_0110;
    localparam logic [15:0] P2_MASK = 16'b1111_1001_1001_1111;

    logic [3:0] p1_idx;
    logic [3:0] p2_idx;

    // bit 15 - {row, col}
    assign p1_idx = ~{i_p1_row, i_p1_col};
    assign p2_idx = ~{i_p2_row, i_p2_col};

    // one cycle, lines up with the sram read data
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_p1_opaque <= 1'b0;
            o_p2_opaque <= 1'b0;
        end else begin
            o_p1_opaque <= P1_MASK[p1_idx];
            o_p2_opaque <= P2_MASK[p2_idx];
        end
    end

endmodule

// File: hw/frame_decoder.sv
`include "arena_params.svh"

module frame_decoder (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  arena_pkg::coord_t     i_fetch_x,
    input  arena_pkg::coord_t     i_fetch_y,
    input  logic                  i_fetch_active,
    input  arena_pkg::coord_t     i_p1_x,
    input  arena_pkg::coord_t     i_p1_y,
    input  arena_pkg::coord_t     i_p2_x,
    input  arena_pkg::coord_t     i_p2_y,
    output arena_pkg::sram_addr_t o_rd_addr,
    input  arena_pkg::sram_word_t i_rd_data,
    output arena_pkg::rgb_t       o_rgb,
    output logic                  o_rgb_valid
);
    localparam arena_pkg::coord_t SPRITE = `ARENA_SPRITE_SIZE;

    arena_pkg::coord_t p1_dx;
    arena_pkg::coord_t p1_dy;
    arena_pkg::coord_t p2_dx;
    arena_pkg::coord_t p2_dy;
    logic              p1_box;
    logic              p2_box;
    logic              p1_opaque;
    logic              p2_opaque;
    logic              p1_hit_q;
    logic              p2_hit_q;
    logic              valid_q;
    arena_pkg::rgb_t   bg_rgb;

    // y*32+x, the sram registers it at the end of this cycle
    assign o_rd_addr = {i_fetch_y[4:0], i_fetch_x[4:0]};

    // left of or above the box the offset wraps far past the sprite size
    assign p1_dx  = i_fetch_x - i_p1_x;
    assign p1_dy  = i_fetch_y - i_p1_y;
    assign p2_dx  = i_fetch_x - i_p2_x;
    assign p2_dy  = i_fetch_y - i_p2_y;
    assign p1_box = (p1_dx < SPRITE) && (p1_dy < SPRITE);
    assign p2_box = (p2_dx < SPRITE) && (p2_dy < SPRITE);

    sprite_table u_sprite_table (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_p1_row    (p1_dy[1:0]),
        .i_p1_col    (p1_dx[1:0]),
        .i_p2_row    (p2_dy[1:0]),
        .i_p2_col    (p2_dx[1:0]),
        .o_p1_opaque (p1_opaque),
        .o_p2_opaque (p2_opaque)
    );

    // stage 1, box hits travel with the texel lookup
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q  <= 1'b0;
            p1_hit_q <= 1'b0;
            p2_hit_q <= 1'b0;
        end else begin
            valid_q  <= i_fetch_active;
            p1_hit_q <= p1_box;
            p2_hit_q <= p2_box;
        end
    end

    // rgb565 to 888, low bits zero
    assign bg_rgb = {i_rd_data[15:11], 3'b000, i_rd_data[10:5], 2'b00,
                     i_rd_data[4:0], 3'b000};

    // stage 2, player 1 wins on overlap
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rgb_valid <= 1'b0;
            o_rgb       <= '0;
        end else begin
            o_rgb_valid <= valid_q;
            if (!valid_q) begin
                o_rgb <= '0;
            end else if (p1_hit_q && p1_opaque) begin
                o_rgb <= `ARENA_P1_COLOR;
            end else if (p2_hit_q && p2_opaque) begin
                o_rgb <= `ARENA_P2_COLOR;
            end else begin
                o_rgb <= bg_rgb;
            end
        end
    end

endmodule

// File: hw/sram_port.sv
module sram_port (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_bg_req,
    input  arena_pkg::sram_addr_t i_bg_addr,
    input  arena_pkg::sram_word_t i_bg_data,
    output logic                  o_bg_ack,
    input  logic                  i_fetch_active,
    input  arena_pkg::sram_addr_t i_rd_addr,
    output arena_pkg::sram_addr_t o_sram_addr,
    output arena_pkg::sram_word_t o_sram_wdata,
    output logic                  o_sram_we_n
);
    arena_pkg::wr_state_t state;
    logic                 wr_strobe;
    logic                 ack_q;

    // pending write goes out on the first cycle with no fetch
    assign wr_strobe = !i_fetch_active &&
                       ((state == arena_pkg::WR_WRITE) ||
                        ((state == arena_pkg::WR_IDLE) && i_bg_req));

    assign o_sram_we_n  = !wr_strobe;
    assign o_sram_addr  = wr_strobe ? i_bg_addr : i_rd_addr;
    assign o_sram_wdata = i_bg_data;
    assign o_bg_ack     = ack_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= arena_pkg::WR_IDLE;
            ack_q <= 1'b0;
        end else begin
            // ack follows req down one cycle later
            ack_q <= (state == arena_pkg::WR_ACK) && i_bg_req;
            case (state)
                arena_pkg::WR_IDLE: begin
                    if (i_bg_req) begin
                        state <= wr_strobe ? arena_pkg::WR_ACK : arena_pkg::WR_WRITE;
                    end
                end
                arena_pkg::WR_WRITE: begin
                    if (wr_strobe) begin
                        state <= arena_pkg::WR_ACK;
                    end
                end
                arena_pkg::WR_ACK: begin
                    if (!i_bg_req) begin
                        state <= arena_pkg::WR_IDLE;
                    end
                end
                default: state <= arena_pkg::WR_IDLE;
            endcase
        end
    end

endmodule

// File: hw/arena_top.sv
module arena_top (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_start,
    input  logic                  i_restart,
    input  logic                  i_right,
    input  logic                  i_left,
    input  logic                  i_jump,
    input  logic                  i_squat,
    input  logic                  i_bg_req,
    input  arena_pkg::sram_addr_t i_bg_addr,
    input  arena_pkg::sram_word_t i_bg_data,
    output logic                  o_bg_ack,
    output arena_pkg::sram_addr_t o_sram_addr,
    output arena_pkg::sram_word_t o_sram_wdata,
    output logic                  o_sram_we_n,
    input  arena_pkg::sram_word_t i_sram_rdata,
    output logic                  o_h_sync,
    output logic                  o_v_sync,
    output arena_pkg::rgb_t       o_rgb,
    output logic                  o_rgb_valid
);
    arena_pkg::coord_t     fetch_x;
    arena_pkg::coord_t     fetch_y;
    logic                  fetch_active;
    logic                  frame_start;
    arena_pkg::coord_t     p1_x;
    arena_pkg::coord_t     p1_y;
    arena_pkg::coord_t     p2_x;
    arena_pkg::coord_t     p2_y;
    arena_pkg::sram_addr_t rd_addr;

    raster_timing u_raster_timing (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .o_fetch_x      (fetch_x),
        .o_fetch_y      (fetch_y),
        .o_fetch_active (fetch_active),
        .o_frame_start  (frame_start),
        .o_h_sync       (o_h_sync),
        .o_v_sync       (o_v_sync)
    );

    game_control u_game_control (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_start       (i_start),
        .i_restart     (i_restart),
        .i_right       (i_right),
        .i_left        (i_left),
        .i_jump        (i_jump),
        .i_squat       (i_squat),
        .i_frame_start (frame_start),
        .o_p1_x        (p1_x),
        .o_p1_y        (p1_y),
        .o_p2_x        (p2_x),
        .o_p2_y        (p2_y)
    );

    frame_decoder u_frame_decoder (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_fetch_x      (fetch_x),
        .i_fetch_y      (fetch_y),
        .i_fetch_active (fetch_active),
        .i_p1_x         (p1_x),
        .i_p1_y         (p1_y),
        .i_p2_x         (p2_x),
        .i_p2_y         (p2_y),
        .o_rd_addr      (rd_addr),
        .i_rd_data      (i_sram_rdata),
        .o_rgb          (o_rgb),
        .o_rgb_valid    (o_rgb_valid)
    );

    // background loads only get the bus during blanking
    sram_port u_sram_port (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_bg_req       (i_bg_req),
        .i_bg_addr      (i_bg_addr),
        .i_bg_data      (i_bg_data),
        .o_bg_ack       (o_bg_ack),
        .i_fetch_active (fetch_active),
        .i_rd_addr      (rd_addr),
        .o_sram_addr    (o_sram_addr),
        .o_sram_wdata   (o_sram_wdata),
        .o_sram_we_n    (o_sram_we_n)
    );

endmodule

// File: verif/arena_tb.sv
`include "arena_params.svh"

module arena_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_WORDS = 768;
    localparam int FRAME_CYCLES = 1120;
    localparam int N_STEPS = 10;
    localparam int ACT_IDLE = 0;
    localparam int ACT_LOAD = 1;
    localparam int ACT_START = 2;
    localparam int ACT_BUTTONS = 3;
    localparam int ACT_RESTART = 4;

    logic                  i_clk = 1'b0;
    logic                  i_rst_n;
    logic                  i_start;
    logic                  i_restart;
    logic                  i_right;
    logic                  i_left;
    logic                  i_jump;
    logic                  i_squat;
    logic                  i_bg_req;
    arena_pkg::sram_addr_t i_bg_addr;
    arena_pkg::sram_word_t i_bg_data;
    logic                  o_bg_ack;
    arena_pkg::sram_addr_t o_sram_addr;
    arena_pkg::sram_word_t o_sram_wdata;
    logic                  o_sram_we_n;
    arena_pkg::sram_word_t i_sram_rdata;
    logic                  o_h_sync;
    logic                  o_v_sync;
    arena_pkg::rgb_t       o_rgb;
    logic                  o_rgb_valid;

    arena_pkg::sram_word_t mem [N_WORDS];
    arena_pkg::sram_word_t ref_bg [N_WORDS];

    // step table with buttons as {squat, jump, left, right}
    int         step_act [N_STEPS];
    logic [3:0] step_btn [N_STEPS];
    int         step_frames [N_STEPS];
    logic       step_check [N_STEPS];
    int         step_exp_x [N_STEPS];
    int         step_exp_y [N_STEPS];

    int          m_p1_x;
    int          m_p1_y;
    int          m_p2_x;
    int          m_p2_y;
    logic        m_play;
    logic [15:0] lfsr;
    int          red_x;
    int          red_y;
    int          blue_x;
    int          blue_y;
    int          active_reqs;
    int          cycle_cnt = 0;
    int          timeout_limit = 1 << 30;
    logic [1:0]  wr_hist = 2'b00;

    arena_top dut0 (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_restart    (i_restart),
        .i_right      (i_right),
        .i_left       (i_left),
        .i_jump       (i_jump),
        .i_squat      (i_squat),
        .i_bg_req     (i_bg_req),
        .i_bg_addr    (i_bg_addr),
        .i_bg_data    (i_bg_data),
        .o_bg_ack     (o_bg_ack),
        .o_sram_addr  (o_sram_addr),
        .o_sram_wdata (o_sram_wdata),
        .o_sram_we_n  (o_sram_we_n),
        .i_sram_rdata (i_sram_rdata),
        .o_h_sync     (o_h_sync),
        .o_v_sync     (o_v_sync),
        .o_rgb        (o_rgb),
        .o_rgb_valid  (o_rgb_valid)
    );

    always #5 i_clk = ~i_clk;

    // synchronous sram with one cycle of read latency
    always @(posedge i_clk) begin
        if (!o_sram_we_n && (o_sram_addr < N_WORDS)) begin
            mem[o_sram_addr] <= o_sram_wdata;
        end
        i_sram_rdata <= (o_sram_addr < N_WORDS) ? mem[o_sram_addr] : 16'h0000;
    end

    task automatic report_failure();
        $display("test failed");
        $fatal(1);
    endtask

    always @(posedge i_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_limit);
            report_failure();
        end
    end

    // the pixel fetched in a write cycle leaves the pipeline two cycles later
    always @(negedge i_clk) begin
        if (o_rgb_valid && wr_hist[1]) begin
            $display("a background write took the sram during active pixel fetch");
            report_failure();
        end
        wr_hist = {wr_hist[0], !o_sram_we_n};
    end

    task automatic check_rgb(input string name, input arena_pkg::rgb_t got,
                             input arena_pkg::rgb_t exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_coord(input string name, input arena_pkg::coord_t got,
                               input arena_pkg::coord_t exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_sync(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            report_failure();
        end
    endtask

    // pattern before any load uses every address bit
    function automatic arena_pkg::sram_word_t fill_word(input logic [9:0] a);
        return {a, a[9:4]} ^ 16'hA5C3;
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic arena_pkg::rgb_t expand565(input arena_pkg::sram_word_t w);
        return {w[15:11], 3'b000, w[10:5], 2'b00, w[4:0], 3'b000};
    endfunction

    // row strings read left to right from column 0
    function automatic logic texel_opaque(input logic is_p2, input int row, input int col);
        logic [15:0] mask;
        mask = is_p2 ? 16'b1111_1001_1001_1111 : 16'b0110_1111_1111_0110;
        return mask[15 - (row * 4 + col)];
    endfunction

    function automatic logic in_box(input int x, input int y, input int px, input int py);
        return (x >= px) && (x < px + `ARENA_SPRITE_SIZE) &&
               (y >= py) && (y < py + `ARENA_SPRITE_SIZE);
    endfunction

    function automatic arena_pkg::rgb_t expected_rgb(input int x, input int y);
        if (in_box(x, y, m_p1_x, m_p1_y) && texel_opaque(1'b0, y - m_p1_y, x - m_p1_x)) begin
            return `ARENA_P1_COLOR;
        end
        if (in_box(x, y, m_p2_x, m_p2_y) && texel_opaque(1'b1, y - m_p2_y, x - m_p2_x)) begin
            return `ARENA_P2_COLOR;
        end
        return expand565(ref_bg[y * 32 + x]);
    endfunction

    function automatic int clamp(input int v, input int hi);
        return (v < 0) ? 0 : ((v > hi) ? hi : v);
    endfunction

    function automatic int chase(input int pos, input int target);
        return (pos < target) ? pos + 1 : ((pos > target) ? pos - 1 : pos);
    endfunction

    task automatic set_step(input int idx, input int act, input logic [3:0] btn,
                            input int frames, input logic chk, input int ex, input int ey);
        step_act[idx]    = act;
        step_btn[idx]    = btn;
        step_frames[idx] = frames;
        step_check[idx]  = chk;
        step_exp_x[idx]  = ex;
        step_exp_y[idx]  = ey;
    endtask

    task automatic reset_players();
        m_p1_x = `ARENA_P1_START_X;
        m_p1_y = `ARENA_P1_START_Y;
        m_p2_x = `ARENA_P2_START_X;
        m_p2_y = `ARENA_P2_START_Y;
    endtask

    // both players move from the positions of the last frame
    task automatic advance_players();
        int old_x;
        int old_y;
        if (m_play) begin
            old_x  = m_p1_x;
            old_y  = m_p1_y;
            m_p1_x = clamp(m_p1_x + int'(i_right) - int'(i_left), 28);
            m_p1_y = clamp(m_p1_y + int'(i_squat) - int'(i_jump), 20);
            m_p2_x = chase(m_p2_x, old_x);
            m_p2_y = chase(m_p2_y, old_y);
        end
    endtask

    task automatic wait_vsync();
        @(negedge o_v_sync);
        #1;
    endtask

    task automatic pulse_control(input logic is_restart);
        i_start   = !is_restart;
        i_restart = is_restart;
        @(posedge i_clk);
        #1;
        i_start   = 1'b0;
        i_restart = 1'b0;
    endtask

    task automatic run_frame(input logic do_check);
        int   n;
        int   x;
        int   y;
        int   gap;
        logic hs_exp;
        red_x  = -1;
        blue_x = -1;
        for (n = 0; n < N_WORDS; n++) begin
            // line gaps hold the front porch, the sync pulse and the back porch
            gap = 0;
            @(negedge i_clk);
            while (!o_rgb_valid) begin
                gap++;
                if (do_check && (n > 0)) begin
                    hs_exp = !((gap > `ARENA_H_FRONT) &&
                               (gap <= `ARENA_H_FRONT + `ARENA_H_SYNC));
                    check_sync("o_h_sync", o_h_sync, hs_exp);
                end
                @(negedge i_clk);
            end
            x = n % 32;
            y = n / 32;
            if (do_check) begin
                check_rgb($sformatf("o_rgb at (%0d,%0d)", x, y), o_rgb, expected_rgb(x, y));
                check_sync("o_h_sync", o_h_sync, 1'b1);
                check_sync("o_v_sync", o_v_sync, 1'b1);
            end
            if ((o_rgb === `ARENA_P1_COLOR) && (red_x < 0)) begin
                red_x = x;
                red_y = y;
            end
            if ((o_rgb === `ARENA_P2_COLOR) && (blue_x < 0)) begin
                blue_x = x;
                blue_y = y;
            end
        end
    endtask

    // diamond starts one pixel right of its box and the ring at its corner
    task automatic check_positions();
        int dx;
        int dy;
        dx = (m_p1_x > m_p2_x) ? m_p1_x - m_p2_x : m_p2_x - m_p1_x;
        dy = (m_p1_y > m_p2_y) ? m_p1_y - m_p2_y : m_p2_y - m_p1_y;
        check_coord("p1 box x", arena_pkg::coord_t'(red_x - 1), arena_pkg::coord_t'(m_p1_x));
        check_coord("p1 box y", arena_pkg::coord_t'(red_y), arena_pkg::coord_t'(m_p1_y));
        if ((dx >= `ARENA_SPRITE_SIZE) || (dy >= `ARENA_SPRITE_SIZE)) begin
            check_coord("p2 box x", arena_pkg::coord_t'(blue_x), arena_pkg::coord_t'(m_p2_x));
            check_coord("p2 box y", arena_pkg::coord_t'(blue_y), arena_pkg::coord_t'(m_p2_y));
        end
    endtask

    task automatic load_background();
        int a;
        int b;
        arena_pkg::sram_word_t w;
        for (a = 0; a < N_WORDS; a++) begin
            w = '0;
            for (b = 0; b < 16; b++) begin
                w    = {w[14:0], lfsr[0]};
                lfsr = lfsr_next(lfsr);
            end
            ref_bg[a] = w;
            if (o_rgb_valid) begin
                active_reqs++;
            end
            i_bg_req  = 1'b1;
            i_bg_addr = arena_pkg::sram_addr_t'(a);
            i_bg_data = w;
            do @(negedge i_clk); while (!o_bg_ack);
            @(posedge i_clk);
            #1;
            // ack has to hold until req drops
            check_bit("o_bg_ack", o_bg_ack, 1'b1);
            i_bg_req = 1'b0;
            do @(negedge i_clk); while (o_bg_ack);
            @(posedge i_clk);
            #1;
        end
        if (active_reqs == 0) begin
            $display("no background write was requested during active video");
            report_failure();
        end
    endtask

    initial begin
        int s;
        int f;
        int total;
        i_rst_n   = 1'b0;
        i_start   = 1'b0;
        i_restart = 1'b0;
        i_right   = 1'b0;
        i_left    = 1'b0;
        i_jump    = 1'b0;
        i_squat   = 1'b0;
        i_bg_req  = 1'b0;
        i_bg_addr = '0;
        i_bg_data = '0;
        i_sram_rdata <= '0;
        lfsr        = 16'd35465;
        active_reqs = 0;
        m_play      = 1'b0;
        reset_players();
        for (s = 0; s < N_WORDS; s++) begin
            mem[s] <= fill_word(s[9:0]);
            ref_bg[s] = fill_word(s[9:0]);
        end

        set_step(0, ACT_IDLE,    4'b0000,  1, 1'b1,  4, 10);
        set_step(1, ACT_LOAD,    4'b0000, 20, 1'b0,  4, 10);
        set_step(2, ACT_IDLE,    4'b0000,  1, 1'b1,  4, 10);
        set_step(3, ACT_BUTTONS, 4'b0001,  2, 1'b1,  4, 10);
        set_step(4, ACT_START,   4'b0001, 30, 1'b1, 28, 10);
        set_step(5, ACT_BUTTONS, 4'b0100, 14, 1'b1, 28,  0);
        set_step(6, ACT_BUTTONS, 4'b1010, 10, 1'b1, 19,  9);
        set_step(7, ACT_IDLE,    4'b0000, 30, 1'b1, 18, 10);
        set_step(8, ACT_RESTART, 4'b0001,  3, 1'b1,  4, 10);
        set_step(9, ACT_START,   4'b1000,  4, 1'b1,  4, 13);
        total = 0;
        for (s = 0; s < N_STEPS; s++) begin
            total += step_frames[s];
        end
        timeout_limit = (total + 4) * FRAME_CYCLES;

        @(posedge i_clk);
        @(negedge i_clk);
        check_sync("o_h_sync", o_h_sync, 1'b1);
        check_sync("o_v_sync", o_v_sync, 1'b1);
        check_bit("o_rgb_valid", o_rgb_valid, 1'b0);
        check_bit("o_bg_ack", o_bg_ack, 1'b0);
        check_bit("o_sram_we_n", o_sram_we_n, 1'b1);
        check_rgb("o_rgb", o_rgb, '0);
        @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;

        for (s = 0; s < N_STEPS; s++) begin
            wait_vsync();
            {i_squat, i_jump, i_left, i_right} = step_btn[s];
            if (step_act[s] == ACT_LOAD) begin
                load_background();
            end else begin
                if (step_act[s] == ACT_START) begin
                    pulse_control(1'b0);
                    m_play = 1'b1;
                end else if (step_act[s] == ACT_RESTART) begin
                    pulse_control(1'b1);
                    m_play = 1'b0;
                    reset_players();
                end
                for (f = 0; f < step_frames[s]; f++) begin
                    if (f > 0) begin
                        wait_vsync();
                    end
                    run_frame(step_check[s]);
                    if (step_check[s]) begin
                        check_positions();
                    end
                    advance_players();
                end
                if (step_check[s]) begin
                    check_coord("p1 box x", arena_pkg::coord_t'(red_x - 1),
                                arena_pkg::coord_t'(step_exp_x[s]));
                    check_coord("p1 box y", arena_pkg::coord_t'(red_y),
                                arena_pkg::coord_t'(step_exp_y[s]));
                end
            end
        end

        $display("test passed");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+hw
hw/arena_pkg.sv
hw/raster_timing.sv
hw/game_control.sv
hw/sprite_table.sv
hw/frame_decoder.sv
hw/sram_port.sv
hw/arena_top.sv
verif/arena_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the arena testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f filelist.f --top-module arena_tb \
    -Mdir obj_dir -o arena_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/arena_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "test failed" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

echo "simulation finished cleanly"
exit 0
